// File: src/mips_settings.svh
//----------------------------
// mips settings
// widths and memory size shared by the core and its testbench
//----------------------------

`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

`define MIPS_WIDTH     32  // data and address width
`define MIPS_REGBITS   5   // register index width
`define MIPS_MEM_WORDS 64  // external memory depth, address taken modulo

`endif

// File: src/mips_pkg.sv
//----------------------------
// mips package
// opcodes, function codes, FSM states and the control word
//----------------------------
`default_nettype none

package mips_pkg;

   typedef enum logic [5:0] {
      RTYPE = 6'b000000,
      J     = 6'b000010,
      BEQ   = 6'b000100,
      BNE   = 6'b000101,
      ADDI  = 6'b001000,
      ORI   = 6'b001101,
      LW    = 6'b100011,
      SW    = 6'b101011,
      HALT  = 6'b111111
   } opcode_t;

   typedef enum logic [5:0] {
      F_ADD = 6'b100000,
      F_SUB = 6'b100010,
      F_AND = 6'b100100,
      F_OR  = 6'b100101,
      F_XOR = 6'b100110,
      F_NOR = 6'b100111,
      F_SLT = 6'b101010
   } funct_t;

   typedef enum logic [3:0] {
      ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_ADD, ALU_SUB, ALU_SLT
   } alu_op_t;

   typedef enum logic [1:0] {MODE_ADD, MODE_SUB, MODE_FUNCT, MODE_IMM} alu_mode_t;

   typedef enum logic [3:0] {
      FETCH, DECODE, MEMADR, LWRD, LWWR, SWWR, RTYPEEX, RTYPEWR,
      ITYPEEX, ITYPEWR, BREX, JEX, HALTED
   } state_t;

   typedef enum logic [1:0] {PC_ALU, PC_BRANCH, PC_JUMP} pc_src_t;

   typedef enum logic [1:0] {SRCB_REG, SRCB_ONE, SRCB_IMM} src_b_t;

   typedef struct packed {
      logic      ir_write;
      logic      pc_write;
      logic      branch;
      logic      branch_ne;   // taken when not zero
      logic      reg_write;
      logic      reg_dst;     // 1 selects rd, 0 selects rt
      logic      mem_to_reg;
      logic      i_or_d;      // 1 puts alu_out on the address
      logic      src_a;       // 1 selects A, 0 selects pc
      src_b_t    src_b;
      alu_mode_t alu_mode;
      pc_src_t   pc_src;
   } ctrl_t;

   // ---- instruction layout ----
   typedef struct packed {
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      funct_t     funct;
   } r_fields_t;

   typedef struct packed {
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
   } i_fields_t;

   typedef union packed {
      r_fields_t   r;
      i_fields_t   i;
      logic [25:0] target;  // j format
   } fields_t;

   typedef struct packed {
      opcode_t op;
      fields_t f;
   } instr_t;

endpackage

`default_nettype wire

// File: src/mips_regfile.sv
//----------------------------
// mips register file
// 2 read ports, 1 write port
//----------------------------
`default_nettype none
`include "mips_settings.svh"

module mips_regfile (
   input  logic                      clk,
   input  logic                      reg_write,
   input  logic [`MIPS_REGBITS-1:0]  ra1,
   input  logic [`MIPS_REGBITS-1:0]  ra2,
   input  logic [`MIPS_REGBITS-1:0]  wa,
   input  logic [`MIPS_WIDTH-1:0]    wd,
   output logic [`MIPS_WIDTH-1:0]    rd1,
   output logic [`MIPS_WIDTH-1:0]    rd2
);

   logic [`MIPS_WIDTH-1:0] regs [0:(1<<`MIPS_REGBITS)-1];

   always_ff @(posedge clk)
   begin
      if (reg_write)
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];  // r0 reads zero
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// File: src/mips_alu.sv
//----------------------------
// mips alu
// operation decode, result and zero flag
//----------------------------
`default_nettype none
`include "mips_settings.svh"

module mips_alu
   import mips_pkg::*;
(
   input  alu_mode_t               alu_mode,
   input  opcode_t                 op,
   input  funct_t                  funct,
   input  logic [`MIPS_WIDTH-1:0]  a,
   input  logic [`MIPS_WIDTH-1:0]  b,
   output logic [`MIPS_WIDTH-1:0]  result,
   output logic                    zero
);

   alu_op_t alu_op;

   always_comb
   begin
      alu_op = ALU_ADD;
      case (alu_mode)
         MODE_SUB: alu_op = ALU_SUB;
         MODE_FUNCT:
         begin
            case (funct)
               F_SUB:   alu_op = ALU_SUB;
               F_AND:   alu_op = ALU_AND;
               F_OR:    alu_op = ALU_OR;
               F_XOR:   alu_op = ALU_XOR;
               F_NOR:   alu_op = ALU_NOR;
               F_SLT:   alu_op = ALU_SLT;
               default: alu_op = ALU_ADD;
            endcase
         end
         MODE_IMM:  alu_op = (op == ORI) ? ALU_OR : ALU_ADD;
         default:   alu_op = ALU_ADD;  // address and pc math
      endcase
   end

   always_comb
   begin
      case (alu_op)
         ALU_AND: result = a & b;
         ALU_OR:  result = a | b;
         ALU_XOR: result = a ^ b;
         ALU_NOR: result = ~(a | b);
         ALU_SUB: result = a - b;
         ALU_SLT: result = {{(`MIPS_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
         default: result = a + b;
      endcase
   end

   assign zero = (result == '0);

endmodule

`default_nettype wire

// File: src/mips_control.sv
//----------------------------
// mips control
// multicycle FSM, drives the control word and memory strobes
//----------------------------
`default_nettype none

module mips_control
   import mips_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  opcode_t op,
   output ctrl_t   ctrl,
   output logic    mem_read,
   output logic    mem_write,
   output logic    halted
);

   state_t state;
   state_t next_state;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= FETCH;
      else
         state <= next_state;
   end

   //----------------------------
   // next state
   //----------------------------
   always_comb
   begin
      next_state = FETCH;
      case (state)
         FETCH:   next_state = DECODE;
         DECODE:
         begin
            case (op)
               LW, SW:    next_state = MEMADR;
               RTYPE:     next_state = RTYPEEX;
               ADDI, ORI: next_state = ITYPEEX;
               BEQ, BNE:  next_state = BREX;
               J:         next_state = JEX;
               HALT:      next_state = HALTED;
               default:   next_state = FETCH;  // undefined opcode, no effect
            endcase
         end
         MEMADR:  next_state = (op == LW) ? LWRD : SWWR;
         LWRD:    next_state = LWWR;
         RTYPEEX: next_state = RTYPEWR;
         ITYPEEX: next_state = ITYPEWR;
         HALTED:  next_state = HALTED;  // only reset leaves
         default: next_state = FETCH;
      endcase
   end

   //----------------------------
   // outputs per state
   //----------------------------
   always_comb
   begin
      ctrl      = '0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      halted    = 1'b0;
      case (state)
         FETCH:
         begin
            mem_read      = 1'b1;
            ctrl.ir_write = 1'b1;
            ctrl.pc_write = 1'b1;
            ctrl.src_b    = SRCB_ONE;  // pc + 1
         end
         MEMADR:
         begin
            ctrl.src_a = 1'b1;
            ctrl.src_b = SRCB_IMM;
         end
         LWRD:
         begin
            mem_read    = 1'b1;
            ctrl.i_or_d = 1'b1;
         end
         LWWR:
         begin
            ctrl.reg_write  = 1'b1;
            ctrl.mem_to_reg = 1'b1;
         end
         SWWR:
         begin
            mem_write   = 1'b1;
            ctrl.i_or_d = 1'b1;
         end
         RTYPEEX:
         begin
            ctrl.src_a    = 1'b1;
            ctrl.alu_mode = MODE_FUNCT;
         end
         RTYPEWR:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.reg_dst   = 1'b1;
         end
         ITYPEEX:
         begin
            ctrl.src_a    = 1'b1;
            ctrl.src_b    = SRCB_IMM;
            ctrl.alu_mode = MODE_IMM;
         end
         ITYPEWR: ctrl.reg_write = 1'b1;
         BREX:
         begin
            ctrl.src_a     = 1'b1;
            ctrl.alu_mode  = MODE_SUB;  // compare A and B
            ctrl.branch    = 1'b1;
            ctrl.branch_ne = (op == BNE);
            ctrl.pc_src    = PC_BRANCH;
         end
         JEX:
         begin
            ctrl.pc_write = 1'b1;
            ctrl.pc_src   = PC_JUMP;
         end
         HALTED:  halted = 1'b1;
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// File: src/mips_datapath.sv
//----------------------------
// mips datapath
// pc, ir and staging registers, operand muxes, branch decision
//----------------------------
`default_nettype none
`include "mips_settings.svh"

module mips_datapath
   import mips_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  ctrl_t                   ctrl,
   input  logic [`MIPS_WIDTH-1:0]  mem_data,
   output opcode_t                 op,
   output logic [`MIPS_WIDTH-1:0]  adr,
   output logic [`MIPS_WIDTH-1:0]  write_data
);

   logic [`MIPS_WIDTH-1:0]   pc;
   logic [`MIPS_WIDTH-1:0]   next_pc;
   instr_t                   instr;
   logic [`MIPS_WIDTH-1:0]   mdr;
   logic [`MIPS_WIDTH-1:0]   a_reg;
   logic [`MIPS_WIDTH-1:0]   b_reg;
   logic [`MIPS_WIDTH-1:0]   alu_out;
   logic [`MIPS_WIDTH-1:0]   rd1;
   logic [`MIPS_WIDTH-1:0]   rd2;
   logic [`MIPS_WIDTH-1:0]   wd;
   logic [`MIPS_REGBITS-1:0] wa;
   logic [`MIPS_WIDTH-1:0]   src_a_val;
   logic [`MIPS_WIDTH-1:0]   src_b_val;
   logic [`MIPS_WIDTH-1:0]   alu_result;
   logic [`MIPS_WIDTH-1:0]   imm_ext;
   logic [`MIPS_WIDTH-1:0]   jump_adr;
   logic                     zero;
   logic                     pc_en;

   //----------------------------
   // registers
   //----------------------------
   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= '0;
      else if (pc_en)
         pc <= next_pc;
   end

   always_ff @(posedge clk)
   begin
      if (ctrl.ir_write)
         instr <= instr_t'(mem_data);
      mdr     <= mem_data;
      a_reg   <= rd1;
      b_reg   <= rd2;
      alu_out <= alu_result;
   end

   assign op         = instr.op;
   assign write_data = b_reg;
   assign imm_ext    = {{(`MIPS_WIDTH-16){1'b0}}, instr.f.i.imm};     // zero extended
   assign jump_adr   = {{(`MIPS_WIDTH-26){1'b0}}, instr.f.target};

   assign adr       = ctrl.i_or_d ? alu_out : pc;
   assign wa        = ctrl.reg_dst ? instr.f.r.rd : instr.f.r.rt;
   assign wd        = ctrl.mem_to_reg ? mdr : alu_out;
   assign src_a_val = ctrl.src_a ? a_reg : pc;

   always_comb
   begin
      case (ctrl.src_b)
         SRCB_ONE: src_b_val = {{(`MIPS_WIDTH-1){1'b0}}, 1'b1};
         SRCB_IMM: src_b_val = imm_ext;
         default:  src_b_val = b_reg;
      endcase
   end

   always_comb
   begin
      case (ctrl.pc_src)
         PC_BRANCH: next_pc = imm_ext;  // absolute word address
         PC_JUMP:   next_pc = jump_adr;
         default:   next_pc = alu_result;
      endcase
   end

   // beq taken on zero, bne on not zero
   assign pc_en = ctrl.pc_write | (ctrl.branch & (zero ^ ctrl.branch_ne));

   mips_regfile rf (
      .clk       (clk),
      .reg_write (ctrl.reg_write),
      .ra1       (instr.f.r.rs),
      .ra2       (instr.f.r.rt),
      .wa        (wa),
      .wd        (wd),
      .rd1       (rd1),
      .rd2       (rd2)
   );

   mips_alu alu (
      .alu_mode (ctrl.alu_mode),
      .op       (instr.op),
      .funct    (instr.f.r.funct),
      .a        (src_a_val),
      .b        (src_b_val),
      .result   (alu_result),
      .zero     (zero)
   );

endmodule

`default_nettype wire

// File: src/mips_core.sv
//----------------------------
// mips core
// multicycle cpu, control plus datapath
//----------------------------
`default_nettype none
`include "mips_settings.svh"

module mips_core
   import mips_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic [`MIPS_WIDTH-1:0]  mem_data,
   output logic                    mem_read,
   output logic                    mem_write,
   output logic [`MIPS_WIDTH-1:0]  adr,
   output logic [`MIPS_WIDTH-1:0]  write_data,
   output logic                    halted
);

   ctrl_t   ctrl;
   opcode_t op;

   mips_control control (
      .clk       (clk),
      .reset     (reset),
      .op        (op),
      .ctrl      (ctrl),
      .mem_read  (mem_read),
      .mem_write (mem_write),
      .halted    (halted)
   );

   mips_datapath datapath (
      .clk        (clk),
      .reset      (reset),
      .ctrl       (ctrl),
      .mem_data   (mem_data),
      .op         (op),
      .adr        (adr),
      .write_data (write_data)
   );

endmodule

`default_nettype wire

// File: verif/mips_properties.sv
//----------------------------
// mips properties
// memory strobe and halt rules on the core ports
//----------------------------
`default_nettype none

module mips_properties (
   input logic clk,
   input logic reset,
   input logic mem_read,
   input logic mem_write,
   input logic halted
);

   timeunit 1ns;
   timeprecision 100ps;

   int unsigned fail_count = 0;  // read by the testbench at the end

   strobe_exclusive: assert property (@(posedge clk) !(mem_read && mem_write))
   else
   begin
      fail_count++;
      $error("mem_read and mem_write high together");
   end

   no_write_in_reset: assert property (@(posedge clk) reset |-> !mem_write)
   else
   begin
      fail_count++;
      $error("mem_write high during reset");
   end

   no_write_after_reset: assert property (@(posedge clk) $fell(reset) |-> !mem_write)
   else
   begin
      fail_count++;
      $error("mem_write high in the first cycle after reset");
   end

   //----------------------------
   // halted is sticky and quiet
   //----------------------------
   halt_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
   else
   begin
      fail_count++;
      $error("halted dropped without reset");
   end

   halt_quiet: assert property (@(posedge clk) disable iff (reset)
                                halted |-> (!mem_read && !mem_write))
   else
   begin
      fail_count++;
      $error("memory strobe while halted");
   end

endmodule

bind mips_core mips_properties props (
   .clk       (clk),
   .reset     (reset),
   .mem_read  (mem_read),
   .mem_write (mem_write),
   .halted    (halted)
);

`default_nettype wire

// File: verif/mips_tb.sv
//----------------------------
// mips testbench
// memory model, LFSR program, store log and timing checks
//----------------------------
`default_nettype none
`include "mips_settings.svh"

module mips_tb
   import mips_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int          WORDS        = `MIPS_MEM_WORDS;
   localparam int          ABITS        = $clog2(`MIPS_MEM_WORDS);
   localparam int          WAIT_LIMIT   = 2000;
   localparam int          QUIET_CYCLES = 20;
   localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;
   localparam logic [15:0] RES_BASE     = 16'd48;    // result words 48..62
   localparam logic [15:0] DATA_ADR     = 16'd63;
   localparam logic [15:0] SKIP_MARK    = 16'hbad0;

   typedef struct packed {
      logic [`MIPS_WIDTH-1:0] adr;
      logic [`MIPS_WIDTH-1:0] data;
   } store_t;

   logic                   clk;
   logic                   reset;
   logic [`MIPS_WIDTH-1:0] mem_data;
   logic                   mem_read;
   logic                   mem_write;
   logic [`MIPS_WIDTH-1:0] adr;
   logic [`MIPS_WIDTH-1:0] write_data;
   logic                   halted;

   logic [`MIPS_WIDTH-1:0] mem [0:WORDS-1];
   logic                   wr_pending = 1'b0;
   store_t                 wr_next;
   store_t                 store_log [$];
   store_t                 exp_log [$];
   string                  exp_name [$];
   logic [31:0]            lfsr;
   int                     cycle;
   int                     exp_cycles;
   int                     pc_build;
   int                     check_errors;
   int                     timeout_errors;
   int                     prop_errors;

   mips_core dut (
      .clk        (clk),
      .reset      (reset),
      .mem_data   (mem_data),
      .mem_read   (mem_read),
      .mem_write  (mem_write),
      .adr        (adr),
      .write_data (write_data),
      .halted     (halted)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
   begin
      if (reset)
         cycle <= 0;
      else
         cycle <= cycle + 1;  // index of the current cycle
   end

   //----------------------------
   // memory model
   //----------------------------
   assign mem_data = mem[adr[ABITS-1:0]];  // address modulo depth

   always @(negedge clk)
   begin
      wr_pending   <= mem_write;
      wr_next.adr  <= adr;
      wr_next.data <= write_data;
   end

   always @(posedge clk)
   begin
      if (wr_pending)
      begin
         mem[wr_next.adr[ABITS-1:0]] <= wr_next.data;
         store_log.push_back(wr_next);
      end
   end

   //----------------------------
   // random numbers
   //----------------------------
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ LFSR_TAPS;
      return n;
   endfunction

   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         v    = {v[30:0], lfsr[0]};  // one step per bit
         lfsr = lfsr_step(lfsr);
      end
      return v;
   endfunction

   //----------------------------
   // program builder
   //----------------------------
   function automatic logic [31:0] enc_r(input funct_t fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt);
      return {RTYPE, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] enc_i(input opcode_t op, input logic [4:0] rt,
                                         input logic [4:0] rs, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] enc_j(input logic [25:0] target);
      return {J, target};
   endfunction

   function automatic int cycles_of(input opcode_t op);
      case (op)
         LW:          return 5;
         BEQ, BNE, J: return 3;
         HALT:        return 2;  // then HALTED
         default:     return 4;  // r-type, addi, ori, sw
      endcase
   endfunction

   task automatic put_instr(input logic [31:0] word, input bit executed);
      mem[pc_build[ABITS-1:0]] = word;
      pc_build++;
      if (executed)
         exp_cycles += cycles_of(opcode_t'(word[31:26]));
   endtask

   task automatic expect_store(input string name, input logic [15:0] a,
                               input logic [31:0] d);
      store_t s;
      s.adr  = {16'd0, a};
      s.data = d;
      exp_log.push_back(s);
      exp_name.push_back(name);
   endtask

   task automatic build_program();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
      logic [31:0] nor_ab;
      int          i;
      for (i = 0; i < WORDS; i++)
         mem[i[ABITS-1:0]] = {HALT, 26'(i)};  // a runaway fetch halts
      pc_build   = 0;
      exp_cycles = 0;
      a = random_bits(16);
      b = random_bits(16);
      if (b == a)
         b = a ^ 32'd1;  // bne below needs r1 != r2
      c = random_bits(16);
      d = random_bits(32);
      nor_ab = ~(a | b);

      // arithmetic, results stored from RES_BASE up
      put_instr(enc_i(ADDI, 5'd1, 5'd0, a[15:0]), 1'b1);
      put_instr(enc_i(ORI, 5'd2, 5'd0, b[15:0]), 1'b1);
      put_instr(enc_r(F_ADD, 5'd3, 5'd1, 5'd2), 1'b1);
      put_instr(enc_r(F_SUB, 5'd4, 5'd1, 5'd2), 1'b1);
      put_instr(enc_r(F_AND, 5'd5, 5'd1, 5'd2), 1'b1);
      put_instr(enc_r(F_OR, 5'd6, 5'd1, 5'd2), 1'b1);
      put_instr(enc_r(F_XOR, 5'd7, 5'd1, 5'd2), 1'b1);
      put_instr(enc_r(F_NOR, 5'd8, 5'd1, 5'd2), 1'b1);
      put_instr(enc_r(F_SLT, 5'd9, 5'd8, 5'd1), 1'b1);  // negative vs positive
      put_instr(enc_r(F_SLT, 5'd10, 5'd1, 5'd2), 1'b1);
      put_instr(enc_r(F_SLT, 5'd11, 5'd2, 5'd1), 1'b1);
      for (i = 1; i <= 11; i++)
         put_instr(enc_i(SW, 5'(i), 5'd0, RES_BASE + 16'(i - 1)), 1'b1);
      expect_store("addi", RES_BASE, a);
      expect_store("ori", RES_BASE + 16'd1, b);
      expect_store("add", RES_BASE + 16'd2, a + b);
      expect_store("sub", RES_BASE + 16'd3, a - b);
      expect_store("and", RES_BASE + 16'd4, a & b);
      expect_store("or", RES_BASE + 16'd5, a | b);
      expect_store("xor", RES_BASE + 16'd6, a ^ b);
      expect_store("nor", RES_BASE + 16'd7, nor_ab);
      expect_store("slt negative", RES_BASE + 16'd8,
                   ($signed(nor_ab) < $signed(a)) ? 32'd1 : 32'd0);
      expect_store("slt r1 r2", RES_BASE + 16'd9, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
      expect_store("slt r2 r1", RES_BASE + 16'd10, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);

      // load and use, then r0
      put_instr(enc_i(ADDI, 5'd13, 5'd0, 16'd40), 1'b1);
      put_instr(enc_i(LW, 5'd12, 5'd13, DATA_ADR - 16'd40), 1'b1);  // base plus offset
      put_instr(enc_i(ADDI, 5'd14, 5'd12, c[15:0]), 1'b1);
      put_instr(enc_i(SW, 5'd14, 5'd0, RES_BASE + 16'd11), 1'b1);
      put_instr(enc_i(ADDI, 5'd0, 5'd1, 16'h0077), 1'b1);  // write to r0 is lost
      put_instr(enc_i(SW, 5'd0, 5'd0, RES_BASE + 16'd12), 1'b1);
      expect_store("load and add", RES_BASE + 16'd11, d + c);
      expect_store("r0 store", RES_BASE + 16'd12, 32'd0);

      // control flow with markers
      put_instr(enc_i(ADDI, 5'd16, 5'd0, SKIP_MARK), 1'b1);
      put_instr(enc_i(ADDI, 5'd17, 5'd0, 16'h0a11), 1'b1);
      put_instr(enc_i(ADDI, 5'd18, 5'd0, 16'h0a12), 1'b1);
      put_instr(enc_i(BEQ, 5'd1, 5'd1, 16'(pc_build + 2)), 1'b1);  // taken
      put_instr(enc_i(SW, 5'd16, 5'd0, RES_BASE + 16'd13), 1'b0);
      put_instr(enc_i(BNE, 5'd1, 5'd1, 16'(pc_build + 7)), 1'b1);  // not taken, aims at halt
      put_instr(enc_i(SW, 5'd17, 5'd0, RES_BASE + 16'd13), 1'b1);
      put_instr(enc_i(BNE, 5'd2, 5'd1, 16'(pc_build + 2)), 1'b1);  // taken
      put_instr(enc_i(SW, 5'd16, 5'd0, RES_BASE + 16'd13), 1'b0);
      put_instr(enc_j(26'(pc_build + 2)), 1'b1);
      put_instr(enc_i(SW, 5'd16, 5'd0, RES_BASE + 16'd13), 1'b0);
      put_instr(enc_i(SW, 5'd18, 5'd0, RES_BASE + 16'd14), 1'b1);
      put_instr({HALT, 26'd0}, 1'b1);
      mem[DATA_ADR[ABITS-1:0]] = d;
      expect_store("bne not taken marker", RES_BASE + 16'd13, 32'h0000_0a11);
      expect_store("jump target marker", RES_BASE + 16'd14, 32'h0000_0a12);
   endtask

   //----------------------------
   // checks
   //----------------------------
   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act === exp)
      else
      begin
         check_errors++;
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_first_fetch();
      @(negedge clk);
      check_value("first fetch strobes", 32'(3'b100), 32'({mem_read, mem_write, halted}));
      check_value("first fetch adr", 32'd0, adr);
   endtask

   task automatic wait_for_halt();
      int n;
      n = 0;
      while (!halted && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (!halted)
      begin
         timeout_errors++;
         $display("timeout while waiting for halted to rise after %0d cycles", WAIT_LIMIT);
      end
      else
         check_value("halt cycle", 32'(exp_cycles), 32'(cycle));
   endtask

   task automatic check_quiet();
      int i;
      for (i = 0; i < QUIET_CYCLES; i++)
      begin
         @(negedge clk);
         assert (!mem_read && !mem_write)
         else
         begin
            check_errors++;
            $display("memory strobe seen %0d cycles after halt", i + 1);
         end
      end
   endtask

   task automatic check_stores();
      int i;
      check_value("store count", 32'(exp_log.size()), 32'(store_log.size()));
      for (i = 0; i < exp_log.size() && i < store_log.size(); i++)
      begin
         check_value({exp_name[i], " adr"}, exp_log[i].adr, store_log[i].adr);
         check_value({exp_name[i], " data"}, exp_log[i].data, store_log[i].data);
      end
      for (i = 0; i < store_log.size(); i++)
      begin
         assert (store_log[i].data !== {16'd0, SKIP_MARK})
         else
         begin
            check_errors++;
            $display("skipped marker was stored at adr %h", store_log[i].adr);
         end
      end
   endtask

   //----------------------------
   // main sequence
   //----------------------------
   initial
   begin
      clk            = 1'b0;
      reset          = 1'b1;
      check_errors   = 0;
      timeout_errors = 0;
      prop_errors    = 0;
      lfsr           = 32'h1ed1_ea23;
      build_program();

      repeat (3) @(posedge clk);
      #1 reset = 1'b0;

      check_first_fetch();
      wait_for_halt();
      check_quiet();
      check_stores();

      prop_errors = dut.props.fail_count;
      $display("errors: %0d check, %0d timeout, %0d property",
               check_errors, timeout_errors, prop_errors);
      if (check_errors + timeout_errors + prop_errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+src
src/mips_pkg.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_control.sv
src/mips_datapath.sv
src/mips_core.sv
verif/mips_properties.sv
verif/mips_tb.sv

// File: run.sh
#!/bin/sh
# build and run the mips testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mips_tb -f vlog.f

# keep running past assertion errors so the closing line is printed
./obj_dir/Vmips_tb +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
   exit 1
fi
